// File: Bender.yml
package:
  name: tile_bus

sources:
  - common/tile_pkg.sv
  - wb_bus/wb_bus_arbiter.sv
  - wb_bus/wb_bus_decoder.sv
  - src/tile_sram.sv
  - src/tile_bootrom.sv
  - src/tile_bus_top.sv
  - target: simulation
    files:
      - verification/tile_bus_props.sv
      - verification/tile_bus_tb.sv

// File: common/tile_pkg.sv
// Tile bus package
// Bus widths, region map, local memory sizes, boot ROM image
// and the enum types shared by the tile bus blocks

package tile_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int SEL_WIDTH  = 4;

  // Master 0 is the core data port, master 1 the network adapter
  localparam int NR_MASTERS = 2;
  localparam int MIDX_WIDTH = $clog2(NR_MASTERS);

  ////////////////////////////////////////////////////////////
  // Address map

  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [REGION_MSB-REGION_LSB:0] REGION_SRAM = 4'h0;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_EXT  = 4'h9;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_BOOT = 4'hf;

  // Memory depths and index widths
  // Word index starts at address bit 2
  localparam int LMEM_WORDS = 256;
  localparam int LMEM_AW    = $clog2(LMEM_WORDS);
  localparam int BOOT_WORDS = 16;
  localparam int BOOT_AW    = $clog2(BOOT_WORDS);

  // Boot code with entry 0 first
  localparam logic [DATA_WIDTH-1:0] BOOT_IMAGE [BOOT_WORDS] = '{
    32'h1800_0000, 32'ha840_0000, 32'h1860_0000, 32'ha863_0100,
    32'he080_0004, 32'hd403_2000, 32'h8483_0000, 32'he4a4_1000,
    32'h1000_0003, 32'h1500_0000, 32'h9c21_fffc, 32'hd401_4800,
    32'h0400_0002, 32'h1500_0000, 32'h4400_4800, 32'h1500_0000
  };

  ////////////////////////////////////////////////////////////
  // Types

  typedef enum logic [1:0] {
    SLV_SRAM,
    SLV_BOOT,
    SLV_EXT,
    SLV_NONE
  } slave_sel_e;

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

endpackage

// File: sim.f
common/tile_pkg.sv
wb_bus/wb_bus_arbiter.sv
wb_bus/wb_bus_decoder.sv
src/tile_sram.sv
src/tile_bootrom.sv
src/tile_bus_top.sv
verification/tile_bus_props.sv
verification/tile_bus_tb.sv

// File: src/tile_bootrom.sv
// Tile boot ROM
// Serves the fixed boot image one cycle after the strobe.
// Writes are refused with a bus error

`timescale 1ns/10ps

module tile_bootrom (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
  output logic                            ack_o,
  output logic                            err_o,
  output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

  import tile_pkg::*;

  logic                  ack_q;
  logic                  err_q;
  logic                  busy;
  logic [DATA_WIDTH-1:0] rdat_q;

  // Response still pending on the bus
  assign busy = ack_q || err_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= stb_i && !we_i && !busy;
      err_q <= stb_i && we_i && !busy;
    end
  end

  // Image lookup
  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdat_q <= BOOT_IMAGE[adr_i[BOOT_AW+1:2]];
    end
  end

  assign ack_o = ack_q;
  assign err_o = err_q;
  assign dat_o = rdat_q;

endmodule

// File: src/tile_bus_top.sv
// Tile bus top level
// Two Wishbone masters share one bus through a round-robin arbiter.
// The decoder routes to local SRAM, boot ROM or the external port.

`timescale 1ns/10ps

module tile_bus_top (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,

  // Master side, one entry per master
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_cyc_i,
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_stb_i,
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_we_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::ADDR_WIDTH-1:0] m_adr_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0] m_dat_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::SEL_WIDTH-1:0]  m_sel_i,
  output logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0] m_dat_o,
  output logic [tile_pkg::NR_MASTERS-1:0]                         m_ack_o,
  output logic [tile_pkg::NR_MASTERS-1:0]                         m_err_o,

  // External memory port
  output logic                                                    ext_cyc_o,
  output logic                                                    ext_stb_o,
  output logic                                                    ext_we_o,
  output logic [tile_pkg::ADDR_WIDTH-1:0]                         ext_adr_o,
  output logic [tile_pkg::DATA_WIDTH-1:0]                         ext_dat_o,
  output logic [tile_pkg::SEL_WIDTH-1:0]                          ext_sel_o,
  input  logic                                                    ext_ack_i,
  input  logic                                                    ext_err_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0]                         ext_dat_i
);

  import tile_pkg::*;

  ////////////////////////////////////////////////////////////
  // Shared bus after arbitration

  logic                  bus_cyc;
  logic                  bus_stb;
  logic                  bus_we;
  logic [ADDR_WIDTH-1:0] bus_adr;
  logic [DATA_WIDTH-1:0] bus_dat;
  logic [SEL_WIDTH-1:0]  bus_sel;
  logic                  bus_ack;
  logic                  bus_err;
  logic [DATA_WIDTH-1:0] bus_rdat;

  // Local slaves
  logic                  sram_stb;
  logic                  sram_ack;
  logic [DATA_WIDTH-1:0] sram_rdat;
  logic                  boot_stb;
  logic                  boot_ack;
  logic                  boot_err;
  logic [DATA_WIDTH-1:0] boot_rdat;

  ////////////////////////////////////////////////////////////
  // Instances

  wb_bus_arbiter u_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .m_cyc_i    (m_cyc_i),
    .m_stb_i    (m_stb_i),
    .m_we_i     (m_we_i),
    .m_adr_i    (m_adr_i),
    .m_dat_i    (m_dat_i),
    .m_sel_i    (m_sel_i),
    .m_ack_o    (m_ack_o),
    .m_err_o    (m_err_o),
    .m_dat_o    (m_dat_o),
    .bus_cyc_o  (bus_cyc),
    .bus_stb_o  (bus_stb),
    .bus_we_o   (bus_we),
    .bus_adr_o  (bus_adr),
    .bus_dat_o  (bus_dat),
    .bus_sel_o  (bus_sel),
    .bus_ack_i  (bus_ack),
    .bus_err_i  (bus_err),
    .bus_rdat_i (bus_rdat)
  );

  wb_bus_decoder u_decoder (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bus_cyc_i   (bus_cyc),
    .bus_stb_i   (bus_stb),
    .bus_we_i    (bus_we),
    .bus_adr_i   (bus_adr),
    .bus_dat_i   (bus_dat),
    .bus_sel_i   (bus_sel),
    .bus_ack_o   (bus_ack),
    .bus_err_o   (bus_err),
    .bus_rdat_o  (bus_rdat),
    .sram_stb_o  (sram_stb),
    .sram_ack_i  (sram_ack),
    .sram_rdat_i (sram_rdat),
    .boot_stb_o  (boot_stb),
    .boot_ack_i  (boot_ack),
    .boot_err_i  (boot_err),
    .boot_rdat_i (boot_rdat),
    .ext_cyc_o   (ext_cyc_o),
    .ext_stb_o   (ext_stb_o),
    .ext_we_o    (ext_we_o),
    .ext_adr_o   (ext_adr_o),
    .ext_dat_o   (ext_dat_o),
    .ext_sel_o   (ext_sel_o),
    .ext_ack_i   (ext_ack_i),
    .ext_err_i   (ext_err_i),
    .ext_dat_i   (ext_dat_i)
  );

  tile_sram u_sram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stb_i    (sram_stb),
    .we_i     (bus_we),
    .adr_i    (bus_adr),
    .dat_i    (bus_dat),
    .sel_i    (bus_sel),
    .ack_o    (sram_ack),
    .dat_o    (sram_rdat)
  );

  tile_bootrom u_bootrom (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stb_i    (boot_stb),
    .we_i     (bus_we),
    .adr_i    (bus_adr),
    .ack_o    (boot_ack),
    .err_o    (boot_err),
    .dat_o    (boot_rdat)
  );

endmodule

// File: src/tile_sram.sv
// Tile local SRAM
// Single-port data memory with byte-select writes and a registered
// acknowledge one cycle after the strobe

`timescale 1ns/10ps

module tile_sram (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [tile_pkg::ADDR_WIDTH-1:0] adr_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0] dat_i,
  input  logic [tile_pkg::SEL_WIDTH-1:0]  sel_i,
  output logic                            ack_o,
  output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

  import tile_pkg::*;

  logic [DATA_WIDTH-1:0] mem_q [LMEM_WORDS];
  logic [LMEM_AW-1:0]    word_idx;
  logic                  ack_q;
  logic [DATA_WIDTH-1:0] rdat_q;

  // Upper address bits alias onto the array
  assign word_idx = adr_i[LMEM_AW+1:2];

  ////////////////////////////////////////////////////////////
  // Array and read port

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdat_q <= mem_q[word_idx];
      if (we_i) begin
        for (int b = 0; b < SEL_WIDTH; b++) begin
          if (sel_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Drops after one pulse even if stb stays up
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i && !ack_q;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rdat_q;

endmodule

// File: verification/tile_bus_input.txt
# mst kind addr wdata sel wait resp rdata (hex except wait), resp 0 = ack, 1 = err
# kind 0 read, 1 write, 2 both masters read (mst = master served second), 3 fill (wait = words)
0 1 00000040 11223344 f 0 0 00000000
0 1 00000040 aabbccdd 6 0 0 00000000
0 0 00000040 00000000 f 0 0 11bbcc44
1 0 00001040 00000000 f 0 0 11bbcc44
0 0 f0000008 00000000 f 0 0 18600000
1 1 f0000008 deadbeef f 0 1 00000000
1 0 f0000008 00000000 f 0 0 18600000
0 1 90000100 cafef00d 3 4 0 00000000
1 0 90000204 00000000 f 6 0 5a5aa5a5
0 0 90000008 00000000 c 0 0 0badf00d
0 0 30000000 00000000 f 0 1 00000000
1 1 c0000010 12345678 f 0 1 00000000
1 0 f000003c 00000000 f 0 0 15000000
1 2 f0000004 00000000 f 0 0 a8400000
0 0 f0000000 00000000 f 0 0 18000000
0 2 f0000004 00000000 f 0 0 a8400000
1 3 00000200 00000000 f 4 0 00000000

// File: verification/tile_bus_props.sv
// Tile bus protocol checks
// One instance sits in the arbiter, one in the decoder

`timescale 1ns/10ps

module tile_bus_props (
  input logic                            clk_i,
  input logic                            arst_n_i,
  input logic [tile_pkg::NR_MASTERS-1:0] ack_i,
  input logic [tile_pkg::NR_MASTERS-1:0] err_i,
  input logic [tile_pkg::NR_MASTERS-1:0] cyc_i,
  // Strobe or response and the bus cycle it belongs to
  input logic                            stb_i,
  input logic                            stb_cyc_i
);

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !((|ack_i) && (|err_i)))
    else $error("ack and err are high in the same cycle");

  ack_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(ack_i))
    else $error("more than one ack bit is set");

  ack_needs_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_i & ~cyc_i) == '0)
    else $error("ack goes to a master without cyc");

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stb_i |-> stb_cyc_i)
    else $error("stb or response is high outside a bus cycle");

endmodule

bind wb_bus_arbiter tile_bus_props u_arb_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .ack_i     (m_ack_o),
  .err_i     (m_err_o),
  .cyc_i     (m_cyc_i),
  .stb_i     (bus_ack_i || bus_err_i),
  .stb_cyc_i (bus_cyc_o)
);

bind wb_bus_decoder tile_bus_props u_dec_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .ack_i     ({{(tile_pkg::NR_MASTERS-1){1'b0}}, bus_ack_o}),
  .err_i     ({{(tile_pkg::NR_MASTERS-1){1'b0}}, bus_err_o}),
  .cyc_i     ({{(tile_pkg::NR_MASTERS-1){1'b0}}, bus_cyc_i}),
  .stb_i     (ext_stb_o),
  .stb_cyc_i (ext_cyc_o)
);

// File: verification/tile_bus_tb.sv
// Tile bus testbench
// Runs the accesses listed in the input file through both masters,
// models the external memory and checks every response

`timescale 1ns/10ps

module tile_bus_tb;

  import tile_pkg::*;

  localparam int MAX_LINES    = 32;
  localparam int RESET_CYCLES = 10;

  logic                                  clk_i;
  logic                                  arst_n_i;
  logic [NR_MASTERS-1:0]                 m_cyc_i;
  logic [NR_MASTERS-1:0]                 m_stb_i;
  logic [NR_MASTERS-1:0]                 m_we_i;
  logic [NR_MASTERS-1:0][ADDR_WIDTH-1:0] m_adr_i;
  logic [NR_MASTERS-1:0][DATA_WIDTH-1:0] m_dat_i;
  logic [NR_MASTERS-1:0][SEL_WIDTH-1:0]  m_sel_i;
  logic [NR_MASTERS-1:0][DATA_WIDTH-1:0] m_dat_o;
  logic [NR_MASTERS-1:0]                 m_ack_o;
  logic [NR_MASTERS-1:0]                 m_err_o;
  logic                                  ext_cyc_o;
  logic                                  ext_stb_o;
  logic                                  ext_we_o;
  logic [ADDR_WIDTH-1:0]                 ext_adr_o;
  logic [DATA_WIDTH-1:0]                 ext_dat_o;
  logic [SEL_WIDTH-1:0]                  ext_sel_o;
  logic                                  ext_ack_i;
  logic                                  ext_err_i;
  logic [DATA_WIDTH-1:0]                 ext_dat_i;

  // One entry per line of the input file
  logic [3:0]  v_mst  [MAX_LINES];
  logic [3:0]  v_kind [MAX_LINES];
  logic [31:0] v_adr  [MAX_LINES];
  logic [31:0] v_wdat [MAX_LINES];
  logic [3:0]  v_sel  [MAX_LINES];
  int          v_wait [MAX_LINES];
  logic [3:0]  v_resp [MAX_LINES];
  logic [31:0] v_rdat [MAX_LINES];
  int          n_lines = 0;
  int          max_wait = 0;
  int          resp_limit = 20;

  int          err_cnt = 0;
  int          bad_tests = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          rsp_cnt [NR_MASTERS];
  int          fin_order [NR_MASTERS];
  int          fin_seq = 0;
  logic [31:0] lcg_state = 32'hec09_78b0;

  // External memory model state
  int          ext_wait;
  int          ext_cnt = 0;
  logic        ext_err_sel;
  logic [31:0] ext_rdat;
  logic        ext_req;
  logic        ext_stb_seen;
  logic        cap_we;
  logic [31:0] cap_adr;
  logic [31:0] cap_dat;
  logic [3:0]  cap_sel;

  tile_bus_top dut_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_stb_i),
    .m_we_i    (m_we_i),
    .m_adr_i   (m_adr_i),
    .m_dat_i   (m_dat_i),
    .m_sel_i   (m_sel_i),
    .m_dat_o   (m_dat_o),
    .m_ack_o   (m_ack_o),
    .m_err_o   (m_err_o),
    .ext_cyc_o (ext_cyc_o),
    .ext_stb_o (ext_stb_o),
    .ext_we_o  (ext_we_o),
    .ext_adr_o (ext_adr_o),
    .ext_dat_o (ext_dat_o),
    .ext_sel_o (ext_sel_o),
    .ext_ack_i (ext_ack_i),
    .ext_err_i (ext_err_i),
    .ext_dat_i (ext_dat_i)
  );

  ////////////////////////////////////////////////////////////
  // Clock, cycle counter and watchdog

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    for (int i = 0; i < NR_MASTERS; i++) begin
      if (m_ack_o[i] || m_err_o[i]) begin
        rsp_cnt[i]++;
      end
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
    end
    $display("Run stopped at cycle %0d, the tests did not finish in time", cycle_cnt);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // External memory model

  // Samples at the rising edge, answers at the falling edge
  initial begin
    forever begin
      @(posedge clk_i);
      ext_req = ext_stb_o;
      if (ext_req) begin
        ext_stb_seen = 1'b1;
        if (ext_cnt == 0 && !ext_ack_i && !ext_err_i) begin
          cap_we  = ext_we_o;
          cap_adr = ext_adr_o;
          cap_dat = ext_dat_o;
          cap_sel = ext_sel_o;
        end
      end
      @(negedge clk_i);
      if (ext_req && !ext_ack_i && !ext_err_i) begin
        if (ext_cnt >= ext_wait) begin
          ext_ack_i = !ext_err_sel;
          ext_err_i = ext_err_sel;
          ext_dat_i = ext_rdat;
        end else begin
          ext_cnt++;
        end
      end else begin
        ext_ack_i = 1'b0;
        ext_err_i = 1'b0;
        ext_cnt   = 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("verification/tile_bus_input.txt", "r");
    if (fd == 0) begin
      $display("The input file verification/tile_bus_input.txt could not be opened");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %d %h %h", v_mst[n_lines], v_kind[n_lines],
                      v_adr[n_lines], v_wdat[n_lines], v_sel[n_lines], v_wait[n_lines],
                      v_resp[n_lines], v_rdat[n_lines]);
          if (n == 8) begin
            if (v_wait[n_lines] > max_wait) begin
              max_wait = v_wait[n_lines];
            end
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Raises cyc and stb on one master and waits for its ack or err
  task automatic bus_access(input int mi, input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, input logic [3:0] sel,
                            output logic is_err, output logic [31:0] rdat, output int lat);
    logic done;
    done   = 1'b0;
    is_err = 1'b0;
    rdat   = '0;
    lat    = 0;
    @(negedge clk_i);
    m_cyc_i[mi] = 1'b1;
    m_stb_i[mi] = 1'b1;
    m_we_i[mi]  = we;
    m_adr_i[mi] = adr;
    m_dat_i[mi] = wdat;
    m_sel_i[mi] = sel;
    while (!done && lat < resp_limit) begin
      @(posedge clk_i);
      if (m_ack_o[mi] || m_err_o[mi]) begin
        done   = 1'b1;
        is_err = m_err_o[mi];
        rdat   = m_dat_o[mi];
        fin_order[mi] = fin_seq;
        fin_seq++;
      end else begin
        lat++;
      end
    end
    if (!done) begin
      $display("Master %0d got no response for address %h within %0d cycles",
               mi, adr, resp_limit);
      err_cnt++;
    end
    @(negedge clk_i);
    m_cyc_i[mi] = 1'b0;
    m_stb_i[mi] = 1'b0;
    m_we_i[mi]  = 1'b0;
  endtask

  task automatic check_quiet_outputs();
    check_value("m_ack_o", m_ack_o, '0);
    check_value("m_err_o", m_err_o, '0);
    check_value("ext_cyc_o", ext_cyc_o, 1'b0);
    check_value("ext_stb_o", ext_stb_o, 1'b0);
  endtask

  task automatic reset_test();
    int errs_before;
    errs_before = err_cnt;
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      check_quiet_outputs();
    end
    @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      check_quiet_outputs();
    end
    if (err_cnt != errs_before) begin
      bad_tests++;
    end
    $display("test 0 reset: %s", (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // One line of the input file

  task automatic run_test(input int t);
    logic        is_err;
    logic        is_err_b;
    logic [31:0] rdat;
    logic [31:0] rdat_b;
    logic [31:0] pat [16];
    int          lat;
    int          lat_b;
    int          mi;
    int          cnt_a;
    int          cnt_b;
    int          errs_before;
    errs_before  = err_cnt;
    mi           = int'(v_mst[t]) % NR_MASTERS;
    ext_stb_seen = 1'b0;
    ext_wait     = v_wait[t];
    ext_err_sel  = v_resp[t][0];
    ext_rdat     = v_rdat[t];
    case (v_kind[t])
      4'h0, 4'h1: begin
        bus_access(mi, v_kind[t][0], v_adr[t], v_wdat[t], v_sel[t], is_err, rdat, lat);
        check_value("m_err_o", is_err, v_resp[t]);
        if (v_kind[t] == 4'h0 && v_resp[t] == 4'h0) begin
          check_value("m_dat_o", rdat, v_rdat[t]);
        end
        if (v_adr[t][REGION_MSB:REGION_LSB] == REGION_EXT) begin
          check_value("ext_stb_o", ext_stb_seen, 1'b1);
          check_value("ack latency", lat, 2 + v_wait[t]);
          check_value("ext_we_o", cap_we, v_kind[t][0]);
          check_value("ext_adr_o", cap_adr, v_adr[t]);
          check_value("ext_sel_o", cap_sel, v_sel[t]);
          if (v_kind[t] == 4'h1) begin
            check_value("ext_dat_o", cap_dat, v_wdat[t]);
          end
        end else begin
          check_value("ack latency", lat, 2);
          check_value("ext_stb_o", ext_stb_seen, 1'b0);
        end
      end
      4'h2: begin
        cnt_a = rsp_cnt[0];
        cnt_b = rsp_cnt[1];
        fork
          bus_access(0, 1'b0, v_adr[t], '0, v_sel[t], is_err, rdat, lat);
          bus_access(1, 1'b0, v_adr[t], '0, v_sel[t], is_err_b, rdat_b, lat_b);
        join
        check_value("m_err_o[0]", is_err, v_resp[t]);
        check_value("m_err_o[1]", is_err_b, v_resp[t]);
        check_value("m_dat_o[0]", rdat, v_rdat[t]);
        check_value("m_dat_o[1]", rdat_b, v_rdat[t]);
        // The master served first sees an idle bus
        check_value("ack latency", (lat < lat_b) ? lat : lat_b, 2);
        check_value("responses to master 0", rsp_cnt[0] - cnt_a, 1);
        check_value("responses to master 1", rsp_cnt[1] - cnt_b, 1);
        check_value("master served second", (fin_order[1] > fin_order[0]) ? 1 : 0, v_mst[t]);
      end
      4'h3: begin
        // Pattern mixes the LCG with the full word address
        for (int w = 0; w < v_wait[t]; w++) begin
          lcg_state = lcg_next(lcg_state);
          pat[w] = lcg_state ^ (v_adr[t] + 4 * w);
          bus_access(mi, 1'b1, v_adr[t] + 4 * w, pat[w], 4'hf, is_err, rdat, lat);
          check_value("m_err_o", is_err, 1'b0);
        end
        for (int w = 0; w < v_wait[t]; w++) begin
          bus_access(mi, 1'b0, v_adr[t] + 4 * w, '0, 4'hf, is_err, rdat, lat);
          check_value("m_err_o", is_err, 1'b0);
          check_value("m_dat_o", rdat, pat[w]);
        end
      end
      default: begin
        $display("Line %0d holds an unknown access kind %h", t + 1, v_kind[t]);
        err_cnt++;
      end
    endcase
    if (err_cnt != errs_before) begin
      bad_tests++;
    end
    $display("test %0d kind %0h addr %h: %s", t + 1, v_kind[t], v_adr[t],
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    arst_n_i  = 1'b0;
    m_cyc_i   = '0;
    m_stb_i   = '0;
    m_we_i    = '0;
    m_adr_i   = '0;
    m_dat_i   = '0;
    m_sel_i   = '0;
    ext_ack_i = 1'b0;
    ext_err_i = 1'b0;
    ext_dat_i = '0;
    for (int i = 0; i < NR_MASTERS; i++) begin
      rsp_cnt[i]   = 0;
      fin_order[i] = 0;
    end
    load_vectors();
    if (n_lines == 0) begin
      $display("No test lines were read from the input file");
      err_cnt++;
    end else begin
      resp_limit  = max_wait + 10;
      cycle_limit = n_lines * (max_wait + 10) + RESET_CYCLES;
      reset_test();
      for (int t = 0; t < n_lines; t++) begin
        run_test(t);
      end
    end
    $display("tests %0d, failing tests %0d, errors %0d", n_lines + 1, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: wb_bus/wb_bus_arbiter.sv
// Wishbone bus arbiter
// Grants the shared bus to one master at a time in round-robin order,
// forwards its request and returns the response to that master only

`timescale 1ns/10ps

module wb_bus_arbiter (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_cyc_i,
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_stb_i,
  input  logic [tile_pkg::NR_MASTERS-1:0]                         m_we_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::ADDR_WIDTH-1:0] m_adr_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0] m_dat_i,
  input  logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::SEL_WIDTH-1:0]  m_sel_i,
  output logic [tile_pkg::NR_MASTERS-1:0]                         m_ack_o,
  output logic [tile_pkg::NR_MASTERS-1:0]                         m_err_o,
  output logic [tile_pkg::NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0] m_dat_o,
  output logic                                                    bus_cyc_o,
  output logic                                                    bus_stb_o,
  output logic                                                    bus_we_o,
  output logic [tile_pkg::ADDR_WIDTH-1:0]                         bus_adr_o,
  output logic [tile_pkg::DATA_WIDTH-1:0]                         bus_dat_o,
  output logic [tile_pkg::SEL_WIDTH-1:0]                          bus_sel_o,
  input  logic                                                    bus_ack_i,
  input  logic                                                    bus_err_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0]                         bus_rdat_i
);

  import tile_pkg::*;

  arb_state_e            state_q;
  logic [MIDX_WIDTH-1:0] grant_q;
  logic [MIDX_WIDTH-1:0] last_q;
  logic [MIDX_WIDTH-1:0] pick_idx;
  logic                  pick_vld;

  // Search starts right after the master served last
  always_comb begin
    int cand;
    pick_idx = last_q;
    pick_vld = 1'b0;
    for (int k = 1; k <= NR_MASTERS; k++) begin
      cand = (int'(last_q) + k) % NR_MASTERS;
      if (!pick_vld && m_cyc_i[cand]) begin
        pick_idx = MIDX_WIDTH'(cand);
        pick_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      // Master 0 wins the first tie
      last_q  <= MIDX_WIDTH'(NR_MASTERS - 1);
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_vld) begin
            state_q <= ARB_BUSY;
            grant_q <= pick_idx;
          end
        end
        ARB_BUSY: begin
          // Owner released the bus
          if (!m_cyc_i[grant_q]) begin
            state_q <= ARB_IDLE;
            last_q  <= grant_q;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Request forwarding

  assign bus_cyc_o = (state_q == ARB_BUSY) && m_cyc_i[grant_q];
  assign bus_stb_o = bus_cyc_o && m_stb_i[grant_q];
  assign bus_we_o  = m_we_i[grant_q];
  assign bus_adr_o = m_adr_i[grant_q];
  assign bus_dat_o = m_dat_i[grant_q];
  assign bus_sel_o = m_sel_i[grant_q];

  // Responses reach the granted master only
  always_comb begin
    m_ack_o = '0;
    m_err_o = '0;
    m_dat_o = '0;
    if (state_q == ARB_BUSY) begin
      m_ack_o[grant_q] = bus_ack_i;
      m_err_o[grant_q] = bus_err_i;
      m_dat_o[grant_q] = bus_rdat_i;
    end
  end

endmodule

// File: wb_bus/wb_bus_decoder.sv
// Wishbone address decoder
// Selects a slave from the region nibble, gates its strobe, muxes the
// responses back and answers unmapped addresses with a bus error

`timescale 1ns/10ps

module wb_bus_decoder (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // Granted request
  input  logic                            bus_cyc_i,
  input  logic                            bus_stb_i,
  input  logic                            bus_we_i,
  input  logic [tile_pkg::ADDR_WIDTH-1:0] bus_adr_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0] bus_dat_i,
  input  logic [tile_pkg::SEL_WIDTH-1:0]  bus_sel_i,
  output logic                            bus_ack_o,
  output logic                            bus_err_o,
  output logic [tile_pkg::DATA_WIDTH-1:0] bus_rdat_o,

  // Local slaves
  output logic                            sram_stb_o,
  input  logic                            sram_ack_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0] sram_rdat_i,
  output logic                            boot_stb_o,
  input  logic                            boot_ack_i,
  input  logic                            boot_err_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0] boot_rdat_i,

  // External memory port
  output logic                            ext_cyc_o,
  output logic                            ext_stb_o,
  output logic                            ext_we_o,
  output logic [tile_pkg::ADDR_WIDTH-1:0] ext_adr_o,
  output logic [tile_pkg::DATA_WIDTH-1:0] ext_dat_o,
  output logic [tile_pkg::SEL_WIDTH-1:0]  ext_sel_o,
  input  logic                            ext_ack_i,
  input  logic                            ext_err_i,
  input  logic [tile_pkg::DATA_WIDTH-1:0] ext_dat_i
);

  import tile_pkg::*;

  slave_sel_e slave_sel;
  logic       bus_req;
  logic       unmap_err_q;

  assign bus_req = bus_cyc_i && bus_stb_i;

  ////////////////////////////////////////////////////////////
  // Region decode

  always_comb begin
    case (bus_adr_i[REGION_MSB:REGION_LSB])
      REGION_SRAM: slave_sel = SLV_SRAM;
      REGION_BOOT: slave_sel = SLV_BOOT;
      REGION_EXT:  slave_sel = SLV_EXT;
      default:     slave_sel = SLV_NONE;
    endcase
  end

  assign sram_stb_o = bus_req && (slave_sel == SLV_SRAM);
  assign boot_stb_o = bus_req && (slave_sel == SLV_BOOT);

  // External port passes straight through, only stb depends on decode
  assign ext_cyc_o = bus_cyc_i;
  assign ext_stb_o = bus_req && (slave_sel == SLV_EXT);
  assign ext_we_o  = bus_we_i;
  assign ext_adr_o = bus_adr_i;
  assign ext_dat_o = bus_dat_i;
  assign ext_sel_o = bus_sel_i;

  // Single-cycle error pulse for addresses nobody owns
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmap_err_q <= 1'b0;
    end else begin
      unmap_err_q <= bus_req && (slave_sel == SLV_NONE) && !unmap_err_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response mux

  always_comb begin
    bus_ack_o  = 1'b0;
    bus_err_o  = unmap_err_q;
    bus_rdat_o = '0;
    case (slave_sel)
      SLV_SRAM: begin
        bus_ack_o  = sram_ack_i;
        bus_rdat_o = sram_rdat_i;
      end
      SLV_BOOT: begin
        bus_ack_o  = boot_ack_i;
        bus_err_o  = boot_err_i;
        bus_rdat_o = boot_rdat_i;
      end
      SLV_EXT: begin
        // Same-cycle return from the outside
        bus_ack_o  = ext_ack_i && bus_cyc_i;
        bus_err_o  = ext_err_i && bus_cyc_i;
        bus_rdat_o = ext_dat_i;
      end
      default: ;
    endcase
  end

endmodule
